//--- verilog/issue_cfg.svh
// issue stage configuration.
// station size, unit numbering, widths and unit busy times.

`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes and widths
`define RS_DEPTH  4     // station entries, one-hot word.
`define NUM_FU    5
`define FU_W      3     // unit number width.
`define XLEN      32
`define TAG_W     4     // rob entry tag.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// unit numbers on ready_bus and valid_in_bus
`define FU_ALU0   0
`define FU_ALU1   1
`define FU_MUL    2
`define FU_DIV    3
`define FU_SHIFT  4

// busy cycles per unit. none of them is pipelined.
`define LAT_ALU   1
`define LAT_MUL   3
`define LAT_DIV   8
`define LAT_SHIFT 1

`endif

//--- verilog/issue_pkg.sv
// issue stage types.
// opcodes, unit classes and the packets passed between the issue blocks.

`include "issue_cfg.svh"

package issue_pkg;

    // top bit set means a non-alu unit.
    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        OR   = 4'h3,
        XOR  = 4'h4,
        SLT  = 4'h5,
        SLTU = 4'h6,
        PASS = 4'h7,    // loads and branches.
        MUL  = 4'h8,
        MULH = 4'h9,
        DIV  = 4'ha,
        REMU = 4'hb,
        SRL  = 4'hc,
        SRA  = 4'hd,
        SLL  = 4'he
    } alu_op_e;

    typedef enum logic [1:0] {
        ALU,
        MULT,
        DIVD,
        SHIFT
    } fu_class_e;

    typedef struct packed {
        logic              ready;
        logic [`TAG_W-1:0] tag;     // producer, while waiting.
        logic [`XLEN-1:0]  value;
    } operand_t;

    typedef struct packed {
        logic [`TAG_W-1:0] rob_entry;
        alu_op_e           alu_op;
        logic [1:0]        branch_type;
        logic              load;
        operand_t          rs1;
        operand_t          rs2;
    } dispatch_t;

    typedef struct packed {
        logic      busy;
        dispatch_t uop;
        logic      valid_operands;  // busy and both sources ready.
    } rs_entry_t;

    typedef struct packed {
        logic              valid;
        logic [`TAG_W-1:0] tag;
        logic [`XLEN-1:0]  value;
    } cdb_t;

    typedef struct packed {
        logic              valid;
        logic [`TAG_W-1:0] rob_entry;
        alu_op_e           alu_op;
        logic [1:0]        branch_type;
        logic              load;
        logic [`XLEN-1:0]  rs1;
        logic [`XLEN-1:0]  rs2;
        logic [`FU_W-1:0]  fu;
    } issue_t;

    typedef struct packed {
        logic              valid;
        logic [`TAG_W-1:0] rob_entry;
        logic [`FU_W-1:0]  fu;
    } complete_t;

    function automatic fu_class_e op_class(alu_op_e op);
        case (op)
            MUL, MULH:     return MULT;
            DIV, REMU:     return DIVD;
            SRL, SRA, SLL: return SHIFT;
            default:       return ALU;
        endcase
    endfunction

endpackage

//--- verilog/rs_bank.sv
// reservation station.
// holds dispatched micro-ops, catches operands off the cdb and
// releases the entry the scheduler consumes.

`include "issue_cfg.svh"

module rs_bank (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 dispatch_valid,
    input  issue_pkg::dispatch_t                 dispatch,
    input  issue_pkg::cdb_t                      cdb,
    input  logic [`RS_DEPTH-1:0]                 consumed,
    output issue_pkg::rs_entry_t [`RS_DEPTH-1:0] entries,
    output logic                                 rs_full
);

    logic [`RS_DEPTH-1:0] busy_q;
    logic [`RS_DEPTH-1:0] free_oh;
    issue_pkg::dispatch_t uop_q [`RS_DEPTH];
    issue_pkg::dispatch_t dispatch_woken;

    // fills a waiting operand when the broadcast tag matches.
    function automatic issue_pkg::operand_t wake(
        issue_pkg::operand_t op,
        issue_pkg::cdb_t     bc
    );
        issue_pkg::operand_t res;
        res = op;
        if (!op.ready && bc.valid && (bc.tag == op.tag)) begin
            res.ready = 1'b1;
            res.value = bc.value;
        end
        return res;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // allocation

    assign free_oh = ~busy_q & (busy_q + 1'b1);  // lowest free, zero when full.
    assign rs_full = &busy_q;

    // same-edge broadcast also reaches the incoming micro-op.
    always_comb begin
        dispatch_woken     = dispatch;
        dispatch_woken.rs1 = wake(dispatch.rs1, cdb);
        dispatch_woken.rs2 = wake(dispatch.rs2, cdb);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= '0;
        end else begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (dispatch_valid && free_oh[i]) begin
                    busy_q[i] <= 1'b1;
                end else if (consumed[i]) begin
                    busy_q[i] <= 1'b0;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // payload and wakeup

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (dispatch_valid && free_oh[i]) begin
                uop_q[i] <= dispatch_woken;
            end else if (busy_q[i]) begin
                uop_q[i].rs1 <= wake(uop_q[i].rs1, cdb);
                uop_q[i].rs2 <= wake(uop_q[i].rs2, cdb);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            entries[i].busy           = busy_q[i];
            entries[i].uop            = uop_q[i];
            entries[i].valid_operands = busy_q[i] & uop_q[i].rs1.ready
                                        & uop_q[i].rs2.ready;
        end
    end

endmodule

//--- verilog/fu_occupancy.sv
// functional unit occupancy.
// one busy counter per unit. reports each finished unit once, lowest first.

`include "issue_cfg.svh"

module fu_occupancy (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [`NUM_FU-1:0]    valid_in_bus,
    input  logic [`TAG_W-1:0]     issue_rob,
    output logic [`NUM_FU-1:0]    ready_bus,
    output issue_pkg::complete_t  complete
);

    localparam int CNT_W = $clog2(`LAT_DIV + 1);

    logic [CNT_W-1:0]   cnt_q      [`NUM_FU];
    logic [`TAG_W-1:0]  rob_q      [`NUM_FU];
    logic [`TAG_W-1:0]  pend_rob_q [`NUM_FU];
    logic [`NUM_FU-1:0] expire, cand, pick, pend_q;
    logic [`FU_W-1:0]   pick_fu;
    logic [`TAG_W-1:0]  pick_rob;
    logic               done_valid_q;
    logic [`FU_W-1:0]   done_fu_q;
    logic [`TAG_W-1:0]  done_rob_q;

    function automatic logic [CNT_W-1:0] unit_lat(int unsigned unit);
        case (unit)
            `FU_MUL:   return CNT_W'(`LAT_MUL);
            `FU_DIV:   return CNT_W'(`LAT_DIV);
            `FU_SHIFT: return CNT_W'(`LAT_SHIFT);
            default:   return CNT_W'(`LAT_ALU);
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < `NUM_FU; i++) begin
            ready_bus[i] = (cnt_q[i] == '0);
            expire[i]    = (cnt_q[i] == CNT_W'(1));   // hits zero this edge.
        end
    end

    assign cand = expire | pend_q;
    assign pick = cand & (~cand + 1'b1);

    always_comb begin
        pick_fu  = '0;
        pick_rob = rob_q[0];
        for (int i = 0; i < `NUM_FU; i++) begin
            if (pick[i]) begin
                pick_fu  = `FU_W'(i);
                pick_rob = pend_q[i] ? pend_rob_q[i] : rob_q[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `NUM_FU; i++) cnt_q[i] <= '0;
            pend_q       <= '0;
            done_valid_q <= 1'b0;
        end else begin
            for (int i = 0; i < `NUM_FU; i++) begin
                if (valid_in_bus[i]) cnt_q[i] <= unit_lat(i);
                else if (cnt_q[i] != '0) cnt_q[i] <= cnt_q[i] - 1'b1;
            end
            pend_q       <= cand & ~pick;   // losers wait their turn.
            done_valid_q <= |cand;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_FU; i++) begin
            if (valid_in_bus[i]) rob_q[i] <= issue_rob;
            if (expire[i]) pend_rob_q[i] <= rob_q[i];
        end
        done_fu_q  <= pick_fu;
        done_rob_q <= pick_rob;
    end

    assign complete.valid     = done_valid_q;
    assign complete.rob_entry = done_rob_q;
    assign complete.fu        = done_fu_q;

endmodule

//--- verilog/fu_scheduler.sv
// issue scheduler.
// picks the first ready entry whose unit class has a free unit and
// registers the issue packet for that unit.

`include "issue_cfg.svh"

module fu_scheduler (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  issue_pkg::rs_entry_t [`RS_DEPTH-1:0] entries,
    input  logic [`NUM_FU-1:0]                   ready_bus,
    output logic [`RS_DEPTH-1:0]                 consumed,
    output logic [`NUM_FU-1:0]                   valid_in_bus,   // both one-hot.
    output logic [`TAG_W-1:0]                    issue_rob,
    output issue_pkg::issue_t                    issue
);

    issue_pkg::dispatch_t sel;
    logic [`NUM_FU-1:0]   unit_oh;
    logic [`FU_W-1:0]     sel_fu;
    logic                 issue_valid_q;
    issue_pkg::dispatch_t issue_uop_q;
    logic [`FU_W-1:0]     issue_fu_q;

    // free unit for this opcode, alu0 before alu1.
    function automatic logic [`NUM_FU-1:0] route(
        issue_pkg::alu_op_e op,
        logic [`NUM_FU-1:0] rdy
    );
        logic [`NUM_FU-1:0] oh;
        oh = '0;
        case (issue_pkg::op_class(op))
            issue_pkg::ALU: begin
                if (rdy[`FU_ALU0]) oh[`FU_ALU0] = 1'b1;
                else if (rdy[`FU_ALU1]) oh[`FU_ALU1] = 1'b1;
            end
            issue_pkg::MULT:  oh[`FU_MUL]   = rdy[`FU_MUL];
            issue_pkg::DIVD:  oh[`FU_DIV]   = rdy[`FU_DIV];
            default:          oh[`FU_SHIFT] = rdy[`FU_SHIFT];
        endcase
        return oh;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // select. a blocked entry does not hide later ones.
    always_comb begin
        consumed     = '0;
        valid_in_bus = '0;
        sel          = entries[0].uop;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            unit_oh = route(entries[i].uop.alu_op, ready_bus);
            if (entries[i].valid_operands && (|unit_oh) && !(|consumed)) begin
                consumed[i]  = 1'b1;
                valid_in_bus = unit_oh;
                sel          = entries[i].uop;
            end
        end
    end

    always_comb begin
        sel_fu = '0;
        for (int u = 0; u < `NUM_FU; u++) begin
            if (valid_in_bus[u]) sel_fu = `FU_W'(u);
        end
    end

    assign issue_rob = sel.rob_entry;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // issue register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) issue_valid_q <= 1'b0;
        else issue_valid_q <= |valid_in_bus;
    end

    always_ff @(posedge clk) begin
        if (|valid_in_bus) begin
            issue_uop_q <= sel;
            issue_fu_q  <= sel_fu;
        end
    end

    assign issue.valid       = issue_valid_q;
    assign issue.rob_entry   = issue_uop_q.rob_entry;
    assign issue.alu_op      = issue_uop_q.alu_op;
    assign issue.branch_type = issue_uop_q.branch_type;
    assign issue.load        = issue_uop_q.load;
    assign issue.rs1         = issue_uop_q.rs1.value;
    assign issue.rs2         = issue_uop_q.rs2.value;
    assign issue.fu          = issue_fu_q;

endmodule

//--- verilog/exec_issue_top.sv
// execute stage issue side.
// reservation station, unit occupancy and scheduler.

`include "issue_cfg.svh"

module exec_issue_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  dispatch_valid,
    input  issue_pkg::dispatch_t  dispatch,
    input  issue_pkg::cdb_t       cdb,
    output logic                  rs_full,
    output issue_pkg::issue_t     issue,
    output issue_pkg::complete_t  complete
);

    issue_pkg::rs_entry_t [`RS_DEPTH-1:0] entries;
    logic [`RS_DEPTH-1:0]                 consumed;
    logic [`NUM_FU-1:0]                   ready_bus;
    logic [`NUM_FU-1:0]                   valid_in_bus;
    logic [`TAG_W-1:0]                    issue_rob;

    rs_bank u_rs_bank (
        .clk            (clk),
        .arst_n         (arst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .cdb            (cdb),
        .consumed       (consumed),
        .entries        (entries),
        .rs_full        (rs_full)
    );

    fu_occupancy u_fu_occupancy (
        .clk          (clk),
        .arst_n       (arst_n),
        .valid_in_bus (valid_in_bus),
        .issue_rob    (issue_rob),
        .ready_bus    (ready_bus),
        .complete     (complete)
    );

    fu_scheduler u_fu_scheduler (
        .clk          (clk),
        .arst_n       (arst_n),
        .entries      (entries),
        .ready_bus    (ready_bus),
        .consumed     (consumed),
        .valid_in_bus (valid_in_bus),
        .issue_rob    (issue_rob),
        .issue        (issue)
    );

endmodule

//--- sim/exec_issue_assert.sv
// scheduler checks.
// one-hot selection and no issue to a busy unit.

`include "issue_cfg.svh"

module exec_issue_assert (
    input logic                 clk,
    input logic                 arst_n,
    input logic [`RS_DEPTH-1:0] consumed,
    input logic [`NUM_FU-1:0]   valid_in_bus,
    input logic [`NUM_FU-1:0]   ready_bus
);

    a_unit_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(valid_in_bus)) else $error("valid_in_bus has more than one bit set");

    a_entry_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(consumed)) else $error("consumed has more than one bit set");

    a_paired: assert property (@(posedge clk) disable iff (!arst_n)
        (|consumed) == (|valid_in_bus)) else $error("consumed and valid_in_bus disagree");

    // a busy unit never takes a new op.
    a_legal: assert property (@(posedge clk) disable iff (!arst_n)
        (valid_in_bus & ~ready_bus) == '0) else $error("unit selected while not ready");

endmodule

bind fu_scheduler exec_issue_assert u_assert (
    .clk          (clk),
    .arst_n       (arst_n),
    .consumed     (consumed),
    .valid_in_bus (valid_in_bus),
    .ready_bus    (ready_bus)
);

//--- sim/exec_issue_tb.sv
// issue stage testbench.
// seeded random dispatch and wakeup against a cycle model of bank,
// unit counters and selection, plus a directed divide back-pressure run.

`include "issue_cfg.svh"

module exec_issue_tb;

    logic clk = 1'b0;
    logic arst_n;
    logic dispatch_valid;
    issue_pkg::dispatch_t dispatch;
    issue_pkg::cdb_t cdb;
    logic rs_full;
    issue_pkg::issue_t issue;
    issue_pkg::complete_t complete;

    // model state.
    logic                 m_busy [`RS_DEPTH];
    issue_pkg::dispatch_t m_uop  [`RS_DEPTH];
    int                   m_cnt  [`NUM_FU];
    logic [`TAG_W-1:0]    m_rob  [`NUM_FU];
    logic [`TAG_W-1:0]    m_prob [`NUM_FU];
    logic [`NUM_FU-1:0]   m_pend;
    issue_pkg::issue_t    m_issue;
    issue_pkg::complete_t m_comp;

    int seed = 32'h928e;
    int phase, errors, test_base, cycle, n_disp, n_issued, n_done, wait_cnt;
    int last_div, between, div_pairs;
    logic saw_full;
    issue_pkg::dispatch_t dq[$];

    exec_issue_top DUT (.*);

    always #5 clk = ~clk;

    function automatic int unit_lat(int u);
        case (u)
            `FU_MUL:   return `LAT_MUL;
            `FU_DIV:   return `LAT_DIV;
            `FU_SHIFT: return `LAT_SHIFT;
            default:   return `LAT_ALU;
        endcase
    endfunction

    function automatic issue_pkg::operand_t wake_op(issue_pkg::operand_t o, issue_pkg::cdb_t c);
        if (!o.ready && c.valid && c.tag == o.tag) begin
            o.ready = 1'b1;
            o.value = c.value;
        end
        return o;
    endfunction

    function automatic int free_unit(issue_pkg::alu_op_e op);
        case (issue_pkg::op_class(op))
            issue_pkg::ALU:  return (m_cnt[`FU_ALU0] == 0) ? `FU_ALU0 :
                                    (m_cnt[`FU_ALU1] == 0) ? `FU_ALU1 : -1;
            issue_pkg::MULT: return (m_cnt[`FU_MUL] == 0) ? `FU_MUL : -1;
            issue_pkg::DIVD: return (m_cnt[`FU_DIV] == 0) ? `FU_DIV : -1;
            default:         return (m_cnt[`FU_SHIFT] == 0) ? `FU_SHIFT : -1;
        endcase
    endfunction

    function automatic logic model_full();
        logic f;
        f = 1'b1;
        for (int i = 0; i < `RS_DEPTH; i++) f &= m_busy[i];
        return f;
    endfunction

    function automatic logic model_idle();
        logic idle;
        idle = (m_pend == '0) && !m_issue.valid && !m_comp.valid;
        for (int i = 0; i < `RS_DEPTH; i++) idle &= !m_busy[i];
        for (int u = 0; u < `NUM_FU; u++) idle &= (m_cnt[u] == 0);
        return idle;
    endfunction

    function automatic issue_pkg::dispatch_t rand_uop();
        issue_pkg::dispatch_t d;
        logic [3:0] code;
        code = $random(seed);
        d.alu_op = issue_pkg::alu_op_e'((code == 4'hf) ? 4'h0 : code);
        d.rob_entry = $random(seed);
        d.branch_type = $random(seed);
        d.load = $random(seed);
        d.rs1 = {(($random(seed) & 3) != 0), 4'($random(seed)), 32'($random(seed))};
        d.rs2 = {(($random(seed) & 3) != 0), 4'($random(seed)), 32'($random(seed))};
        return d;
    endfunction

    // one clock edge of the model, from pre-edge state and inputs.
    task automatic model_step();
        int sel, unit, pu, fr;
        logic [`NUM_FU-1:0] cand, expire;
        issue_pkg::dispatch_t woken;
        sel = -1;
        unit = -1;
        pu = -1;
        fr = -1;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (sel < 0 && m_busy[i] && m_uop[i].rs1.ready && m_uop[i].rs2.ready
                && free_unit(m_uop[i].alu_op) >= 0) begin
                sel = i;
                unit = free_unit(m_uop[i].alu_op);
            end
        end
        m_issue = '0;
        if (sel >= 0) begin
            m_issue = {1'b1, m_uop[sel].rob_entry, m_uop[sel].alu_op, m_uop[sel].branch_type,
                       m_uop[sel].load, m_uop[sel].rs1.value, m_uop[sel].rs2.value,
                       `FU_W'(unit)};
        end
        // completions, lowest unit first.
        for (int u = 0; u < `NUM_FU; u++) begin
            expire[u] = (m_cnt[u] == 1);
            cand[u] = expire[u] | m_pend[u];
            if (pu < 0 && cand[u]) pu = u;
        end
        m_comp = '0;
        if (pu >= 0) m_comp = {1'b1, (m_pend[pu] ? m_prob[pu] : m_rob[pu]), `FU_W'(pu)};
        m_pend = cand;
        if (pu >= 0) m_pend[pu] = 1'b0;
        for (int u = 0; u < `NUM_FU; u++) begin
            if (expire[u]) m_prob[u] = m_rob[u];
            if (u == unit) begin
                m_cnt[u] = unit_lat(u);
                m_rob[u] = m_issue.rob_entry;
            end else if (m_cnt[u] > 0) m_cnt[u]--;
        end
        // bank.
        for (int i = `RS_DEPTH - 1; i >= 0; i--) if (!m_busy[i]) fr = i;
        woken = dispatch;
        woken.rs1 = wake_op(dispatch.rs1, cdb);
        woken.rs2 = wake_op(dispatch.rs2, cdb);
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (dispatch_valid && i == fr) begin
                m_busy[i] = 1'b1;
                m_uop[i] = woken;
            end else begin
                if (m_busy[i]) begin
                    m_uop[i].rs1 = wake_op(m_uop[i].rs1, cdb);
                    m_uop[i].rs2 = wake_op(m_uop[i].rs2, cdb);
                end
                if (i == sel) m_busy[i] = 1'b0;
            end
        end
        if (dispatch_valid && fr >= 0) n_disp++;
    endtask

    task automatic model_reset();
        for (int i = 0; i < `RS_DEPTH; i++) m_busy[i] = 1'b0;
        for (int u = 0; u < `NUM_FU; u++) m_cnt[u] = 0;
        m_pend = '0;
        m_issue = '0;
        m_comp = '0;
    endtask

    always @(posedge clk) begin
        cycle++;
        if (!arst_n) model_reset();
        else model_step();
        dispatch_valid <= 1'b0;
        cdb.valid <= 1'b0;
        if (phase == 1 || phase == 3) begin
            if (($random(seed) % 3) == 0) cdb <= {1'b1, 4'($random(seed)), 32'($random(seed))};
        end
        if (phase == 1 && !model_full() && ($random(seed) & 1)) begin
            dispatch_valid <= 1'b1;
            dispatch <= rand_uop();
        end else if (phase == 2 && !model_full() && dq.size() > 0) begin
            dispatch_valid <= 1'b1;
            dispatch <= dq.pop_front();
        end
    end

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    // outputs are stable at the falling edge.
    always @(negedge clk) begin
        check_val("rs_full", rs_full, model_full());
        check_val("issue.valid", issue.valid, m_issue.valid);
        check_val("complete.valid", complete.valid, m_comp.valid);
        if (model_full()) saw_full = 1'b1;
        if (m_issue.valid && issue.valid) begin
            n_issued++;
            check_val("issue.rob_entry", issue.rob_entry, m_issue.rob_entry);
            check_val("issue.alu_op", issue.alu_op, m_issue.alu_op);
            check_val("issue.branch_type", issue.branch_type, m_issue.branch_type);
            check_val("issue.load", issue.load, m_issue.load);
            check_val("issue.rs1", issue.rs1, m_issue.rs1);
            check_val("issue.rs2", issue.rs2, m_issue.rs2);
            check_val("issue.fu", issue.fu, m_issue.fu);
            if (phase == 2 && issue_pkg::op_class(issue.alu_op) == issue_pkg::DIVD) begin
                // divider busy LAT_DIV cycles, next divide goes on the following edge.
                if (last_div >= 0) begin
                    check_val("divide issue gap", cycle - last_div, `LAT_DIV + 1);
                    if (between == 0) begin
                        errors++;
                        $display("no ALU or shift op issued between the two divides");
                    end
                    div_pairs++;
                end
                last_div = cycle;
                between = 0;
            end else if (phase == 2) between++;
        end
        if (m_comp.valid && complete.valid) begin
            n_done++;
            check_val("complete.rob_entry", complete.rob_entry, m_comp.rob_entry);
            check_val("complete.fu", complete.fu, m_comp.fu);
        end
    end

    task automatic report_test(string name);
        $display("test %s: %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    task automatic wait_idle(int limit, string what);
        wait_cnt = 0;
        while (!(model_idle() && dq.size() == 0) && wait_cnt < limit) begin
            @(negedge clk);
            wait_cnt++;
        end
        @(posedge clk);
        if (wait_cnt >= limit) begin
            errors++;
            $display("timed out waiting for the %s run to drain", what);
        end
    endtask

    initial begin
        issue_pkg::dispatch_t d;
        arst_n = 1'b0;
        dispatch_valid = 1'b0;
        dispatch = '0;
        cdb = '0;
        phase = 0;
        last_div = -1;
        saw_full = 1'b0;
        model_reset();
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        report_test("reset");

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // random dispatch and wakeup
        saw_full = 1'b0;
        phase <= 1;
        wait_cnt = 0;
        while (n_disp < 300 && wait_cnt < 20000) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (wait_cnt >= 20000) begin
            errors++;
            $display("timed out dispatching random micro-ops");
        end
        phase <= 3;
        wait_idle(5000, "random");
        if (!saw_full) begin
            errors++;
            $display("the station never filled during the random run");
        end
        report_test("random");

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // divides with alu and shift work behind them
        for (int k = 0; k < 6; k++) begin
            d = rand_uop();
            d.alu_op = (k < 2) ? issue_pkg::DIV : (k == 3) ? issue_pkg::SRL : issue_pkg::ADD;
            d.rs1.ready = 1'b1;
            d.rs2.ready = 1'b1;
            dq.push_back(d);
        end
        phase <= 2;
        wait_idle(500, "divide");
        if (div_pairs != 1) begin
            errors++;
            $display("expected one pair of divides, saw %0d", div_pairs);
        end
        report_test("divide");

        check_val("issued minus completed", n_issued - n_done, 0);
        $display("checks done: %0d issued, %0d completed, %0d errors", n_issued, n_done, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #1000000;
        $display("run did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- build.f
+incdir+verilog
verilog/issue_pkg.sv
verilog/rs_bank.sv
verilog/fu_occupancy.sv
verilog/fu_scheduler.sv
verilog/exec_issue_top.sv
sim/exec_issue_assert.sv
sim/exec_issue_tb.sv

//--- Bender.yml
package:
  name: exec_issue

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/issue_pkg.sv
      - verilog/rs_bank.sv
      - verilog/fu_occupancy.sv
      - verilog/fu_scheduler.sv
      - verilog/exec_issue_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/exec_issue_assert.sv
      - sim/exec_issue_tb.sv
